// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_control_unit
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  := Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
logic/cpu_ctrl_pkg.sv
logic/instr_decoder.sv
logic/phase_sequencer.sv
logic/control_word_table.sv
logic/control_unit.sv
testbench/tb_clock_gen.sv
testbench/control_unit_sva.sv
testbench/tb_control_unit.sv

// ==== logic/control_unit.sv ====
`timescale 1ns/100ps

module control_unit
    import cpu_ctrl_pkg::*;
#(
    parameter int DATA_WIDTH = 32     // At least IMM_WIDTH
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [INSTR_WIDTH-1:0] instruction,
    output decoded_instr_t         fields,
    output logic [DATA_WIDTH-1:0]  imm_ext,
    output ctrl_word_t             ctrl,
    output logic                   fetch_en,
    output logic                   exe_en
);

    ctrl_state_e phase;
    opcode_e     raw_opcode;

    instr_decoder #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_instr_decoder (
        .clk         (clk),
        .reset       (reset),
        .phase       (phase),
        .instruction (instruction),
        .raw_opcode  (raw_opcode),
        .fields      (fields),
        .imm_ext     (imm_ext)
    );

    phase_sequencer u_phase_sequencer (
        .clk        (clk),
        .reset      (reset),
        .raw_opcode (raw_opcode),
        .opcode     (fields.opcode),    // Registered copy for the execute decision
        .phase      (phase),
        .fetch_en   (fetch_en),
        .exe_en     (exe_en)
    );

    control_word_table u_control_word_table (
        .phase  (phase),
        .opcode (fields.opcode),
        .ctrl   (ctrl)
    );

endmodule

// ==== logic/control_word_table.sv ====
`timescale 1ns/100ps

module control_word_table
    import cpu_ctrl_pkg::*;
(
    input  ctrl_state_e phase,
    input  opcode_e     opcode,
    output ctrl_word_t  ctrl
);

    // Control word while the opcode executes
    function automatic ctrl_word_t exec_word(opcode_e op);
        ctrl_word_t w;
        w             = '0;
        w.alu_op      = op;
        case (op)
            OP_ADD, OP_SUB, OP_MUL, OP_MOD,
            OP_AND, OP_OR, OP_XOR,
            OP_MOV, OP_MOVEQ, OP_MOVL, OP_MOVG: begin
                w.src_reg_sel = 1'b1;     // Second operand from register
            end
            OP_LAD: begin
                w.reg_write   = 1'b1;
                w.wb_mem_sel  = 1'b1;     // Write back read data
                w.mem_load    = 1'b1;
            end
            OP_STR: begin
                w.mem_store   = 1'b1;     // Address from immediate
            end
            default: begin
                w.src_reg_sel = 1'b0;     // Immediate forms, jumps, branches
            end
        endcase
        return w;
    endfunction

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = OP_NONE;
        case (phase)
            EXECUTE: begin
                ctrl = exec_word(opcode);
            end
            WRITE_BACK: begin
                ctrl.reg_write = 1'b1;    // ALU result into rd
            end
            default: begin
                ctrl.alu_op = OP_NONE;    // Idle word outside execute
            end
        endcase
    end

endmodule

// ==== logic/cpu_ctrl_pkg.sv ====
package cpu_ctrl_pkg;

    localparam int INSTR_WIDTH    = 32;
    localparam int OPCODE_WIDTH   = 5;
    localparam int REG_ADDR_WIDTH = 4;
    localparam int IMM_WIDTH      = 15;

    // Low bit of each instruction field
    localparam int OPCODE_LSB = INSTR_WIDTH - OPCODE_WIDTH;    // Bits 31:27
    localparam int RD_LSB     = OPCODE_LSB - REG_ADDR_WIDTH;   // Bits 26:23
    localparam int RS_LSB     = RD_LSB - REG_ADDR_WIDTH;       // Bits 22:19
    localparam int RT_LSB     = RS_LSB - REG_ADDR_WIDTH;       // Bits 18:15
    localparam int IMM_LSB    = 0;                             // Bits 14:0

    // Codes 1, 30 and 31 are not defined
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_NONE   = 5'd0,     // No operation
        OP_ADD    = 5'd2,
        OP_ADDI   = 5'd3,
        OP_SUB    = 5'd4,
        OP_SUBI   = 5'd5,
        OP_MUL    = 5'd6,
        OP_MULI   = 5'd7,
        OP_MOD    = 5'd8,
        OP_MODI   = 5'd9,
        OP_AND    = 5'd10,
        OP_OR     = 5'd11,
        OP_XOR    = 5'd12,
        OP_NOT    = 5'd13,
        OP_MOV    = 5'd14,
        OP_MOVI   = 5'd15,
        OP_MOVEQ  = 5'd16,
        OP_MOVIEQ = 5'd17,
        OP_MOVL   = 5'd18,
        OP_MOVIL  = 5'd19,
        OP_MOVG   = 5'd20,
        OP_MOVIG  = 5'd21,
        OP_LAD    = 5'd22,    // Load
        OP_STR    = 5'd23,    // Store
        OP_JMP    = 5'd24,
        OP_BEQ    = 5'd25,
        OP_BL     = 5'd26,
        OP_BG     = 5'd27,
        OP_LSFT   = 5'd28,    // Logic shift left
        OP_RSFT   = 5'd29     // Logic shift right
    } opcode_e;

    typedef enum logic [2:0] {
        INIT       = 3'd0,
        FETCH      = 3'd1,
        DECODE     = 3'd2,
        EXECUTE    = 3'd3,
        WRITE_BACK = 3'd4
    } ctrl_state_e;

    typedef struct packed {
        opcode_e                   opcode;
        logic [REG_ADDR_WIDTH-1:0] rd;      // Target register
        logic [REG_ADDR_WIDTH-1:0] rs;      // Source register 1
        logic [REG_ADDR_WIDTH-1:0] rt;      // Source register 2
    } decoded_instr_t;

    typedef struct packed {
        opcode_e alu_op;
        logic    src_reg_sel;   // 1 register operand, 0 immediate
        logic    wb_mem_sel;    // 1 read data, 0 ALU result
        logic    reg_write;
        logic    mem_load;
        logic    mem_store;
    } ctrl_word_t;

    function automatic logic opcode_valid(opcode_e op);
        return op inside {[OP_ADD:OP_RSFT]};
    endfunction

    // ALU and move class, result goes back to the register file
    function automatic logic needs_write_back(opcode_e op);
        return op inside {[OP_ADD:OP_MOVIG], OP_LSFT, OP_RSFT};
    endfunction

endpackage

// ==== logic/instr_decoder.sv ====
`timescale 1ns/100ps

module instr_decoder
    import cpu_ctrl_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrl_state_e            phase,
    input  logic [INSTR_WIDTH-1:0] instruction,
    output opcode_e                raw_opcode,
    output decoded_instr_t         fields,
    output logic [DATA_WIDTH-1:0]  imm_ext
);

    decoded_instr_t        slice;
    logic [IMM_WIDTH-1:0]  imm_field;
    logic [DATA_WIDTH-1:0] imm_sext;

    // Live opcode for the decode decision
    assign raw_opcode = opcode_e'(instruction[OPCODE_LSB +: OPCODE_WIDTH]);

    assign slice.opcode = raw_opcode;
    assign slice.rd     = instruction[RD_LSB +: REG_ADDR_WIDTH];
    assign slice.rs     = instruction[RS_LSB +: REG_ADDR_WIDTH];
    assign slice.rt     = instruction[RT_LSB +: REG_ADDR_WIDTH];

    assign imm_field = instruction[IMM_LSB +: IMM_WIDTH];
    assign imm_sext  = DATA_WIDTH'($signed(imm_field));     // Sign extend to data width

    // Captured at the edge leaving DECODE, held until the next one
    always_ff @(posedge clk) begin
        if (reset) begin
            fields  <= '0;
            imm_ext <= '0;
        end else if (phase == DECODE) begin
            fields  <= slice;
            imm_ext <= imm_sext;
        end
    end

endmodule

// ==== logic/phase_sequencer.sv ====
`timescale 1ns/100ps

module phase_sequencer
    import cpu_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  opcode_e     raw_opcode,
    input  opcode_e     opcode,
    output ctrl_state_e phase,
    output logic        fetch_en,
    output logic        exe_en
);

    ctrl_state_e next_phase;
    logic        decode_ok;     // Instruction on the bus has a defined opcode
    logic        exec_wb;       // Registered opcode writes a register

    assign decode_ok = opcode_valid(raw_opcode);
    assign exec_wb   = needs_write_back(opcode);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= INIT;
        end else begin
            phase <= next_phase;
        end
    end

    always_comb begin
        case (phase)
            INIT: begin
                next_phase = FETCH;
            end
            FETCH: begin
                next_phase = DECODE;
            end
            DECODE: begin
                if (decode_ok) begin
                    next_phase = EXECUTE;
                end else begin
                    next_phase = FETCH;      // Unknown code, skip it
                end
            end
            EXECUTE: begin
                if (exec_wb) begin
                    next_phase = WRITE_BACK;
                end else begin
                    next_phase = FETCH;      // Load, store, jump and branches
                end
            end
            WRITE_BACK: begin
                next_phase = FETCH;
            end
            default: begin
                next_phase = INIT;
            end
        endcase
    end

    // FETCH and EXECUTE last one cycle and never repeat back to back,
    // so the phase decode already gives single-cycle pulses
    assign fetch_en = (phase == FETCH);
    assign exe_en   = (phase == EXECUTE);

endmodule

// ==== testbench/control_unit_sva.sv ====
`timescale 1ns/100ps

module control_unit_sva
    import cpu_ctrl_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       fetch_en,
    input logic       exe_en,
    input ctrl_word_t ctrl
);

    // Fetch and execute pulses are exclusive
    assert property (@(posedge clk) disable iff (reset) !(fetch_en && exe_en))
        else $error("fetch_en and exe_en high together");

    // Execute goes to fetch or to write-back
    assert property (@(posedge clk) disable iff (reset)
        exe_en |=> (fetch_en || ctrl.reg_write))
        else $error("exe_en not followed by fetch_en or write-back");

    // Write-back always returns to fetch, so fetch comes within two cycles of execute
    assert property (@(posedge clk) disable iff (reset)
        (ctrl.reg_write && !exe_en) |=> fetch_en)
        else $error("write-back not followed by fetch_en");

    assert property (@(posedge clk) disable iff (reset) !(ctrl.mem_load && ctrl.mem_store))
        else $error("mem_load and mem_store high together");

endmodule

bind control_unit control_unit_sva u_control_unit_sva (.*);

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter real PERIOD_NS   = 4.0,
    parameter int  RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset <= 1'b0;
    end

endmodule

// ==== testbench/tb_control_unit.sv ====
`timescale 1ns/100ps

module tb_control_unit;
    import cpu_ctrl_pkg::*;

    localparam int DATA_WIDTH = 32;
    localparam int MAX_WAIT   = 20;    // Cycles before a wait gives up

    typedef struct packed {
        decoded_instr_t        fields;
        logic [DATA_WIDTH-1:0] imm;
        ctrl_word_t            ctrl;
        logic [3:0]            cycles;   // Fetch pulse to fetch pulse
        logic                  exec;
    } expect_t;

    logic                   clk;
    logic                   reset;
    logic [INSTR_WIDTH-1:0] instruction;
    decoded_instr_t         fields;
    logic [DATA_WIDTH-1:0]  imm_ext;
    ctrl_word_t             ctrl;
    logic                   fetch_en;
    logic                   exe_en;

    int          errors = 0;
    int          tests = 0;
    logic        aborted = 1'b0;
    logic [31:0] lfsr_state = 32'h20ea;

    tb_clock_gen #(.PERIOD_NS(4.0), .RESET_CYCLES(2)) u_clock_gen (.clk(clk), .reset(reset));

    control_unit #(.DATA_WIDTH(DATA_WIDTH)) dut (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .fields      (fields),
        .imm_ext     (imm_ext),
        .ctrl        (ctrl),
        .fetch_en    (fetch_en),
        .exe_en      (exe_en)
    );

    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Expected decode, execute word and sequence length
    function automatic expect_t reference(logic [31:0] instr);
        expect_t     e;
        logic [4:0]  op;
        op                = instr[31:27];
        e                 = '0;
        e.fields.opcode   = opcode_e'(op);
        e.fields.rd       = instr[26:23];
        e.fields.rs       = instr[22:19];
        e.fields.rt       = instr[18:15];
        e.imm             = {{(DATA_WIDTH-15){instr[14]}}, instr[14:0]};
        e.ctrl.alu_op     = opcode_e'(op);
        e.exec            = (op >= 5'd2 && op <= 5'd29);
        case (op)
            5'd2, 5'd4, 5'd6, 5'd8, 5'd10, 5'd11, 5'd12,
            5'd14, 5'd16, 5'd18, 5'd20: e.ctrl.src_reg_sel = 1'b1;
            5'd22: begin
                e.ctrl.reg_write  = 1'b1;
                e.ctrl.wb_mem_sel = 1'b1;
                e.ctrl.mem_load   = 1'b1;
            end
            5'd23: e.ctrl.mem_store = 1'b1;
            default: e.ctrl.src_reg_sel = 1'b0;
        endcase
        if (!e.exec) begin
            e.cycles = 4'd2;
        end else if ((op <= 5'd21) || op == 5'd28 || op == 5'd29) begin
            e.cycles = 4'd4;     // ALU and move results written back
        end else begin
            e.cycles = 4'd3;
        end
        return e;
    endfunction

    task automatic check_hex(string name, logic [63:0] got, logic [63:0] exp);
        assert (got == exp) else begin
            $display("Error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic ctrl_word_t idle_word();
        ctrl_word_t w;
        w        = '0;
        w.alu_op = OP_NONE;
        return w;
    endfunction

    // Called on a falling edge with fetch_en high, returns on the next one
    task automatic run_instr(logic [31:0] instr, string label);
        expect_t    e;
        ctrl_word_t wb_word;
        int         cycles;
        int         errs_before;
        logic       saw_exe;
        logic       wb_next;
        logic       done;
        e           = reference(instr);
        wb_word     = idle_word();
        wb_word.reg_write = 1'b1;
        errs_before = errors;
        cycles      = 0;
        saw_exe     = 1'b0;
        wb_next     = 1'b0;
        done        = 1'b0;
        instruction = instr;
        while (!done && !aborted) begin
            @(negedge clk);
            cycles++;
            if (wb_next) begin
                check_hex("ctrl (write-back)", 64'(ctrl), 64'(wb_word));
                wb_next = 1'b0;
            end
            if (exe_en) begin
                saw_exe = 1'b1;
                check_hex("fields", 64'(fields), 64'(e.fields));
                check_hex("imm_ext", 64'(imm_ext), 64'(e.imm));
                check_hex("ctrl", 64'(ctrl), 64'(e.ctrl));
                wb_next = (e.cycles == 4'd4);
            end
            if (fetch_en) begin
                done = 1'b1;
            end else if (cycles >= MAX_WAIT) begin
                $display("Timeout waiting for fetch_en after instruction %h", instr);
                errors++;
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            check_hex("fetch cycles", 64'(cycles), 64'(e.cycles));
            check_hex("exe_en seen", 64'(saw_exe), 64'(e.exec));
        end
        tests++;
        $display("Test %0d %s instr %h: %s", tests, label, instr,
                 (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int         waited;
        logic [4:0] bad_codes [3];
        logic [31:0] instr;
        bad_codes   = '{5'd1, 5'd30, 5'd31};
        instruction = '0;

        // Outputs idle through reset and up to the first fetch
        @(posedge clk);
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (reset) begin
                check_hex("fetch_en (reset)", 64'(fetch_en), 64'd0);
            end
            check_hex("exe_en (reset)", 64'(exe_en), 64'd0);
            check_hex("ctrl (reset)", 64'(ctrl), 64'(idle_word()));
            if (!fetch_en && waited >= MAX_WAIT) begin
                $display("Timeout waiting for first fetch_en");
                errors++;
                aborted = 1'b1;
            end
        end while (!fetch_en && !aborted);
        if (!aborted) begin
            tests++;
            $display("Test %0d reset: %s", tests, (errors == 0) ? "ok" : "FAILED");
        end

        // Every defined opcode, odd ones with a negative immediate
        for (int op = 2; op <= 29 && !aborted; op++) begin
            instr = {5'(op), 27'(random_bits(27))};
            instr[14] = op[0];
            run_instr(instr, "opcode");
        end

        for (int i = 0; i < 3 && !aborted; i++) begin
            instr = {bad_codes[i], 27'(random_bits(27))};
            run_instr(instr, "invalid");
        end

        for (int i = 0; i < 200 && !aborted; i++) begin
            run_instr(random_bits(32), "random");
        end

        $display("Tests run %0d, errors %0d", tests, errors);
        if (errors == 0 && !aborted) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
